// File: src/core_pkg.sv
package core_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_idx_t;

    // RV32I major opcodes handled by this core
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK
    } wb_sel_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } fd_reg_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] imm;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        reg_idx_t        rd;
        alu_op_e         alu_op;
        logic            use_imm;
        wb_sel_e         wb_sel;
        logic            reg_write;
        logic            mem_read;
        logic            mem_write;
        logic            is_branch;
        logic            branch_ne;
        logic            is_jal;
        logic            is_halt;
    } de_reg_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] store_data;
        logic [xlen-1:0] link;
        reg_idx_t        rd;
        wb_sel_e         wb_sel;
        logic            reg_write;
        logic            mem_read;
        logic            mem_write;
        logic            is_halt;
    } em_reg_t;

    // retire is valid & reg_write & (rd != 0), registered with the rest
    typedef struct packed {
        logic            valid;
        reg_idx_t        rd;
        logic            reg_write;
        logic [xlen-1:0] result;
        logic            is_halt;
        logic            retire;
    } mw_reg_t;

endpackage

// File: src/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage #(
    parameter logic [core_pkg::xlen-1:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load_stall,
    input  logic                      redirect,
    input  logic [core_pkg::xlen-1:0] redirect_pc,
    input  logic                      halted,
    output logic [core_pkg::xlen-1:0] imem_addr,
    input  logic [core_pkg::xlen-1:0] imem_data,
    output core_pkg::fd_reg_t         fd
);
    import core_pkg::*;

    logic [xlen-1:0] pc;

    // Instruction memory answers in the same cycle
    assign imem_addr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
            fd <= '0;
        end else if (redirect) begin
            // Younger instruction in fd is on the wrong path
            pc       <= redirect_pc;
            fd.valid <= 1'b0;
        end else if (!load_stall && !halted) begin
            pc       <= pc + xlen'(4);
            fd.valid <= 1'b1;
            fd.pc    <= pc;
            fd.instr <= imem_data;
        end
        // Otherwise pc and fd hold
    end

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  core_pkg::fd_reg_t fd,
    input  logic              flush,
    input  logic              load_stall,
    input  core_pkg::mw_reg_t mw,
    output core_pkg::de_reg_t de
);
    import core_pkg::*;

    logic [xlen-1:0] regs [32];
    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    reg_idx_t        rs1;
    reg_idx_t        rs2;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic            wb_en;
    logic            legal;
    logic            issue;
    logic            halt_seen;
    de_reg_t         de_next;

    assign opcode = opcode_e'(fd.instr[6:0]);
    assign funct3 = fd.instr[14:12];
    assign funct7 = fd.instr[31:25];
    assign rs1    = fd.instr[19:15];
    assign rs2    = fd.instr[24:20];

    assign imm_i = {{20{fd.instr[31]}}, fd.instr[31:20]};
    assign imm_s = {{20{fd.instr[31]}}, fd.instr[31:25], fd.instr[11:7]};
    assign imm_b = {{19{fd.instr[31]}}, fd.instr[31], fd.instr[7],
                    fd.instr[30:25], fd.instr[11:8], 1'b0};
    assign imm_j = {{11{fd.instr[31]}}, fd.instr[31], fd.instr[19:12],
                    fd.instr[20], fd.instr[30:21], 1'b0};

    // Register file, written at the end of the writeback cycle
    assign wb_en = mw.valid && mw.reg_write && (mw.rd != '0);

    always_ff @(posedge clk) begin
        if (wb_en) begin
            regs[mw.rd] <= mw.result;
        end
    end

    // Write-through so writeback needs no path into decode
    assign rs1_val = (rs1 == '0) ? '0 : (wb_en && mw.rd == rs1) ? mw.result : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : (wb_en && mw.rd == rs2) ? mw.result : regs[rs2];

    always_comb begin
        de_next         = '0;
        de_next.valid   = 1'b1;
        de_next.pc      = fd.pc;
        de_next.rs1_val = rs1_val;
        de_next.rs2_val = rs2_val;
        de_next.rs1     = rs1;
        de_next.rs2     = rs2;
        de_next.rd      = fd.instr[11:7];
        legal           = 1'b1;
        case (opcode)
            OPC_LUI: begin
                de_next.alu_op    = ALU_PASS_B;
                de_next.use_imm   = 1'b1;
                de_next.imm       = {fd.instr[31:12], 12'b0};
                de_next.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                // ADDI only
                legal             = (funct3 == 3'b000);
                de_next.use_imm   = 1'b1;
                de_next.imm       = imm_i;
                de_next.reg_write = 1'b1;
            end
            OPC_OP: begin
                de_next.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: de_next.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: de_next.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: de_next.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: de_next.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: de_next.alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: de_next.alu_op = ALU_SLT;
                    default:              legal          = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                legal             = (funct3 == 3'b010);
                de_next.use_imm   = 1'b1;
                de_next.imm       = imm_i;
                de_next.mem_read  = 1'b1;
                de_next.wb_sel    = WB_MEM;
                de_next.reg_write = 1'b1;
            end
            OPC_STORE: begin
                legal             = (funct3 == 3'b010);
                de_next.use_imm   = 1'b1;
                de_next.imm       = imm_s;
                de_next.mem_write = 1'b1;
            end
            OPC_BRANCH: begin
                // BEQ and BNE, funct3 bit 0 picks the sense
                legal             = (funct3[2:1] == 2'b00);
                de_next.imm       = imm_b;
                de_next.is_branch = 1'b1;
                de_next.branch_ne = funct3[0];
            end
            OPC_JAL: begin
                de_next.imm       = imm_j;
                de_next.is_jal    = 1'b1;
                de_next.wb_sel    = WB_LINK;
                de_next.reg_write = 1'b1;
            end
            OPC_SYSTEM: begin
                legal           = (fd.instr == 32'h0000_0073);
                de_next.is_halt = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    assign issue = fd.valid && legal && !flush && !load_stall && !halt_seen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de        <= '0;
            halt_seen <= 1'b0;
        end else begin
            if (issue) begin
                de <= de_next;
            end else begin
                de <= '0;
            end
            // Nothing behind the halt gets into execute
            if (issue && de_next.is_halt) begin
                halt_seen <= 1'b1;
            end
        end
    end

endmodule

// File: src/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  core_pkg::de_reg_t         de,
    input  core_pkg::fwd_sel_e        fwd_a,
    input  core_pkg::fwd_sel_e        fwd_b,
    input  logic [core_pkg::xlen-1:0] em_fwd,
    input  core_pkg::mw_reg_t         mw,
    output logic                      redirect,
    output logic [core_pkg::xlen-1:0] redirect_pc,
    output core_pkg::em_reg_t         em
);
    import core_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] rs2_fwd;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] link;
    logic            cond_eq;

    function automatic logic [xlen-1:0] pick_operand(
        fwd_sel_e        sel,
        logic [xlen-1:0] reg_val,
        logic [xlen-1:0] mem_val,
        logic [xlen-1:0] wb_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a    = pick_operand(fwd_a, de.rs1_val, em_fwd, mw.result);
    assign rs2_fwd = pick_operand(fwd_b, de.rs2_val, em_fwd, mw.result);
    assign op_b    = de.use_imm ? de.imm : rs2_fwd;

    always_comb begin
        case (de.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // Branch compare on the forwarded register operands
    assign cond_eq     = (op_a == rs2_fwd);
    assign link        = de.pc + xlen'(4);
    assign redirect_pc = de.pc + de.imm;
    assign redirect    = de.valid && (de.is_jal || (de.is_branch && (cond_eq != de.branch_ne)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            em <= '0;
        end else begin
            em.valid      <= de.valid;
            em.alu_result <= alu_out;
            em.store_data <= rs2_fwd;
            em.link       <= link;
            em.rd         <= de.rd;
            em.wb_sel     <= de.wb_sel;
            em.reg_write  <= de.valid && de.reg_write;
            em.mem_read   <= de.valid && de.mem_read;
            em.mem_write  <= de.valid && de.mem_write;
            em.is_halt    <= de.valid && de.is_halt;
        end
    end

endmodule

// File: src/memory_stage.sv
`timescale 1ns/1ns

module memory_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  core_pkg::em_reg_t em,
    output core_pkg::mw_reg_t mw,
    output logic              halted
);
    import core_pkg::*;

    localparam int idx_w = $clog2(DMEM_WORDS);

    logic [xlen-1:0]  dmem [DMEM_WORDS];
    logic [idx_w-1:0] word_idx;
    logic [xlen-1:0]  load_data;
    logic [xlen-1:0]  wb_value;

    // Word address wraps around the array size
    assign word_idx = idx_w'(em.alu_result[xlen-1:2] % DMEM_WORDS);

    always_ff @(posedge clk) begin
        if (em.valid && em.mem_write) begin
            dmem[word_idx] <= em.store_data;
        end
    end

    assign load_data = dmem[word_idx];

    always_comb begin
        case (em.wb_sel)
            WB_MEM:  wb_value = load_data;
            WB_LINK: wb_value = em.link;
            default: wb_value = em.alu_result;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mw     <= '0;
            halted <= 1'b0;
        end else begin
            mw.valid     <= em.valid;
            mw.rd        <= em.rd;
            mw.reg_write <= em.reg_write;
            mw.result    <= wb_value;
            mw.is_halt   <= em.is_halt;
            mw.retire    <= em.valid && em.reg_write && (em.rd != '0);
            // Sticky until reset
            if (mw.valid && mw.is_halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

// File: src/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit (
    input  core_pkg::fd_reg_t  fd,
    input  core_pkg::de_reg_t  de,
    input  core_pkg::em_reg_t  em,
    input  core_pkg::mw_reg_t  mw,
    output logic               load_stall,
    output core_pkg::fwd_sel_e fwd_a,
    output core_pkg::fwd_sel_e fwd_b
);
    import core_pkg::*;

    reg_idx_t fd_rs1;
    reg_idx_t fd_rs2;
    logic     em_ok;
    logic     mw_ok;

    function automatic fwd_sel_e fwd_source(
        reg_idx_t src,
        logic     em_hit_ok,
        reg_idx_t em_rd,
        logic     mw_hit_ok,
        reg_idx_t mw_rd
    );
        // Younger result in em wins over mw
        if (em_hit_ok && em_rd == src) begin
            return FWD_MEM;
        end else if (mw_hit_ok && mw_rd == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign fd_rs1 = fd.instr[19:15];
    assign fd_rs2 = fd.instr[24:20];

    // Load data only exists from mw onward, hence the one-cycle stall
    assign load_stall = fd.valid && de.valid && de.mem_read && (de.rd != '0) &&
                        (de.rd == fd_rs1 || de.rd == fd_rs2);

    assign em_ok = em.valid && em.reg_write && !em.mem_read && (em.rd != '0);
    assign mw_ok = mw.valid && mw.reg_write && (mw.rd != '0);

    assign fwd_a = fwd_source(de.rs1, em_ok, em.rd, mw_ok, mw.rd);
    assign fwd_b = fwd_source(de.rs2, em_ok, em.rd, mw_ok, mw.rd);

endmodule

// File: src/core_top.sv
`timescale 1ns/1ns

module core_top #(
    parameter logic [core_pkg::xlen-1:0] RESET_PC   = '0,
    parameter int                        DMEM_WORDS = 256
) (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic [core_pkg::xlen-1:0] imem_addr,
    input  logic [core_pkg::xlen-1:0] imem_data,
    output logic                      retire_valid,
    output core_pkg::reg_idx_t        retire_rd,
    output logic [core_pkg::xlen-1:0] retire_data,
    output logic                      halted
);
    import core_pkg::*;

    fd_reg_t         fd;
    de_reg_t         de;
    em_reg_t         em;
    mw_reg_t         mw;
    logic            load_stall;
    logic            redirect;
    logic [xlen-1:0] redirect_pc;
    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) fetch_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_stall (load_stall),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .halted     (halted),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .fd         (fd)
    );

    decode_stage decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .fd        (fd),
        .flush     (redirect),
        .load_stall(load_stall),
        .mw        (mw),
        .de        (de)
    );

    execute_stage execute_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .de         (de),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .em_fwd     (em.alu_result),
        .mw         (mw),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .em         (em)
    );

    memory_stage #(
        .DMEM_WORDS(DMEM_WORDS)
    ) memory_i (
        .clk   (clk),
        .rst_n (rst_n),
        .em    (em),
        .mw    (mw),
        .halted(halted)
    );

    hazard_unit hazard_i (
        .fd        (fd),
        .de        (de),
        .em        (em),
        .mw        (mw),
        .load_stall(load_stall),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b)
    );

    // Retire port comes straight from the writeback register
    assign retire_valid = mw.retire;
    assign retire_rd    = mw.rd;
    assign retire_data  = mw.result;

endmodule

// File: tests/tb_core.sv
`timescale 1ns/1ns

module tb_core;

    localparam int          rom_words = 256;
    localparam logic [31:0] reset_pc  = 32'h0;
    localparam logic [31:0] nop       = 32'h0000_0013;
    localparam logic [31:0] ecall     = 32'h0000_0073;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        halted;

    logic [31:0] rom [rom_words];
    int          prog_len;
    logic [31:0] lfsr_state;
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic [4:0]  got_rd [$];
    logic [31:0] got_data [$];
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          budget_cycles;
    int          cycle_count;

    core_top #(
        .RESET_PC  (reset_pc),
        .DMEM_WORDS(256)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .retire_valid(retire_valid),
        .retire_rd   (retire_rd),
        .retire_data (retire_data),
        .halted      (halted)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Instruction ROM answers in the same cycle
    assign imem_data = rom[imem_addr[9:2]];

    // Retire monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            got_rd.push_back(retire_rd);
            got_data.push_back(retire_data);
        end
    end

    // Watchdog, budget grows as each test loads its program
    initial begin
        cycle_count = 0;
        while (cycle_count <= budget_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: core did not halt within %0d cycles", budget_cycles);
        $display("Testbench failed");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int nbits, output logic [31:0] value);
        int k;
        value = '0;
        for (k = 0; k < nbits; k++) begin
            value      = {value[30:0], lfsr_state[31]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // RV32I encoders
    function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_alu(input logic [6:0] funct7, input logic [2:0] funct3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [2:0] funct3, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", what, expected, actual);
            errors++;
        end
    endtask

    task automatic fill_nops();
        int i;
        for (i = 0; i < rom_words; i++) begin
            rom[i] = nop;
        end
    endtask

    task automatic emit(input logic [31:0] instr);
        rom[prog_len] = instr;
        prog_len++;
    endtask

    task automatic expect_retire(input logic [4:0] rd, input logic [31:0] value);
        exp_rd.push_back(rd);
        exp_data.push_back(value);
    endtask

    // LUI and ADDI pair building a random constant
    task automatic load_const(input logic [4:0] rd, output logic [31:0] value);
        logic [31:0] upper;
        logic [31:0] lower;
        take_bits(20, upper);
        take_bits(12, lower);
        emit(enc_lui(rd, upper[19:0]));
        expect_retire(rd, {upper[19:0], 12'h000});
        emit(enc_addi(rd, rd, lower[11:0]));
        value = {upper[19:0], 12'h000} + sext12(lower[11:0]);
        expect_retire(rd, value);
    endtask

    // Reset goes low here, ROM is rewritten once the core is held
    task automatic start_program();
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        fill_nops();
        prog_len = 0;
        exp_rd.delete();
        exp_data.delete();
        got_rd.delete();
        got_data.delete();
    endtask

    task automatic run_program(input string name);
        int start_errors;
        int n;
        int i;
        start_errors = errors;
        budget_cycles += (prog_len + 20) * 10;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check({name, " reset halted"}, 32'h0, {31'b0, halted});
        check({name, " reset retire_valid"}, 32'h0, {31'b0, retire_valid});
        check({name, " reset pc"}, reset_pc, imem_addr);
        @(posedge clk);
        rst_n <= 1'b1;
        while (halted !== 1'b1) begin
            @(negedge clk);
        end
        // A few more cycles so a stray retire would show up
        repeat (5) @(negedge clk);
        check({name, " retire count"}, exp_rd.size(), got_rd.size());
        n = (exp_rd.size() < got_rd.size()) ? exp_rd.size() : got_rd.size();
        for (i = 0; i < n; i++) begin
            check($sformatf("%s retire %0d rd", name, i), {27'b0, exp_rd[i]},
                  {27'b0, got_rd[i]});
            check($sformatf("%s retire %0d data", name, i), exp_data[i], got_data[i]);
        end
        tests_run++;
        if (errors != start_errors) begin
            tests_failed++;
        end
        $display("Test %s finished with %0d mismatches", name, errors - start_errors);
    endtask

    // Each result feeds the next, so both forwarding paths get used
    task automatic test_alu_chain();
        logic [31:0] a, b, c, d, e, f, g;
        start_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        c = a + b;
        emit(enc_alu(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        expect_retire(5'd3, c);
        d = c - a;
        emit(enc_alu(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
        expect_retire(5'd4, d);
        e = d & c;
        emit(enc_alu(7'h00, 3'b111, 5'd5, 5'd4, 5'd3));
        expect_retire(5'd5, e);
        f = e | b;
        emit(enc_alu(7'h00, 3'b110, 5'd6, 5'd5, 5'd2));
        expect_retire(5'd6, f);
        g = f ^ d;
        emit(enc_alu(7'h00, 3'b100, 5'd7, 5'd6, 5'd4));
        expect_retire(5'd7, g);
        emit(enc_alu(7'h00, 3'b010, 5'd8, 5'd7, 5'd1));
        expect_retire(5'd8, {31'b0, $signed(g) < $signed(a)});
        emit(enc_alu(7'h00, 3'b010, 5'd9, 5'd1, 5'd7));
        expect_retire(5'd9, {31'b0, $signed(a) < $signed(g)});
        emit(ecall);
        run_program("alu_chain");
    endtask

    task automatic test_load_store();
        logic [31:0] vals [3];
        logic [31:0] base;
        logic [11:0] off;
        int i;
        start_program();
        take_bits(6, base);
        base = {22'b0, base[5:0], 4'b0000};
        emit(enc_addi(5'd10, 5'd0, base[11:0]));
        expect_retire(5'd10, base);
        for (i = 0; i < 3; i++) begin
            off = 12'(i * 4);
            load_const(5'd11, vals[i]);
            emit(enc_sw(5'd11, 5'd10, off));
        end
        // Sum right behind the load forces the load-use stall
        for (i = 0; i < 3; i++) begin
            off = 12'(i * 4);
            emit(enc_lw(5'd12, 5'd10, off));
            expect_retire(5'd12, vals[i]);
            emit(enc_alu(7'h00, 3'b000, 5'd13, 5'd12, 5'd10));
            expect_retire(5'd13, vals[i] + base);
        end
        emit(ecall);
        run_program("load_store");
    endtask

    task automatic test_branches();
        logic [31:0] r;
        start_program();
        take_bits(11, r);
        emit(enc_addi(5'd14, 5'd0, r[11:0]));
        expect_retire(5'd14, sext12(r[11:0]));
        emit(enc_addi(5'd15, 5'd0, r[11:0]));
        expect_retire(5'd15, sext12(r[11:0]));
        // BEQ taken over two markers
        emit(enc_branch(3'b000, 5'd14, 5'd15, 13'd12));
        emit(enc_addi(5'd16, 5'd0, 12'h111));
        emit(enc_addi(5'd17, 5'd0, 12'h222));
        // BNE falls through
        emit(enc_branch(3'b001, 5'd14, 5'd15, 13'd12));
        emit(enc_addi(5'd18, 5'd0, 12'h333));
        expect_retire(5'd18, 32'h333);
        emit(enc_addi(5'd19, 5'd0, 12'h444));
        expect_retire(5'd19, 32'h444);
        emit(enc_addi(5'd20, 5'd0, 12'h555));
        expect_retire(5'd20, 32'h555);
        emit(ecall);
        run_program("branches");
    endtask

    task automatic test_jal();
        logic [31:0] r;
        logic [31:0] jal_pc;
        start_program();
        take_bits(11, r);
        emit(enc_addi(5'd21, 5'd0, r[11:0]));
        expect_retire(5'd21, sext12(r[11:0]));
        jal_pc = reset_pc + 32'(prog_len * 4);
        emit(enc_jal(5'd1, 21'd12));
        expect_retire(5'd1, jal_pc + 32'd4);
        emit(enc_addi(5'd22, 5'd0, 12'h666));
        emit(enc_addi(5'd23, 5'd0, 12'h777));
        // Target uses the link straight away
        emit(enc_alu(7'h00, 3'b000, 5'd24, 5'd1, 5'd21));
        expect_retire(5'd24, jal_pc + 32'd4 + sext12(r[11:0]));
        emit(ecall);
        run_program("jal");
    endtask

    task automatic test_x0_halt();
        logic [31:0] r;
        logic [31:0] up;
        start_program();
        take_bits(11, r);
        take_bits(20, up);
        emit(enc_addi(5'd0, 5'd0, r[11:0]));
        emit(enc_lui(5'd0, up[19:0]));
        emit(enc_alu(7'h00, 3'b000, 5'd25, 5'd0, 5'd0));
        expect_retire(5'd25, 32'h0);
        emit(enc_addi(5'd26, 5'd0, r[11:0]));
        expect_retire(5'd26, sext12(r[11:0]));
        emit(enc_alu(7'h00, 3'b000, 5'd27, 5'd0, 5'd26));
        expect_retire(5'd27, sext12(r[11:0]));
        emit(ecall);
        // Nothing past the halt may retire
        emit(enc_addi(5'd28, 5'd0, 12'h123));
        emit(enc_addi(5'd29, 5'd0, 12'h456));
        run_program("x0_halt");
    endtask

    initial begin
        rst_n         = 1'b0;
        lfsr_state    = 32'h7bed_576e;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        budget_cycles = 20;
        prog_len      = 0;
        fill_nops();

        test_alu_chain();
        test_load_store();
        test_branches();
        test_jal();
        test_x0_halt();

        $display("Tests run: %0d, tests with mismatches: %0d, total mismatches: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: flist.f
src/core_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/hazard_unit.sv
src/core_top.sv
tests/tb_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build the core with its testbench, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_core -f flist.f -o tb_core || exit 1

sim_out="$(./obj_dir/tb_core)"
echo "$sim_out"
echo "$sim_out" | grep -qx "Testbench passed" && exit 0 || exit 1
